// ==== flist.f ====
+incdir+hdl
hdl/step_cmp_pkg.sv
hdl/retire_capture.sv
hdl/gpr_shadow.sv
hdl/step_sequencer.sv
hdl/compare_engine.sv
hdl/step_compare_top.sv
test/tb_clkgen.sv
test/tb_step_compare.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the step compare testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_step_compare -f flist.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

# pass only if the testbench printed the pass line
echo "$out" | grep -qx "Test OK"

// ==== test/tb_step_compare.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "step_cmp_consts.svh"

module tb_step_compare import step_cmp_pkg::*; ();

   localparam int     NSTEPS       = 200;
   localparam int     CLK_NS       = 40;
   localparam int     CYC_PER_STEP = 400;
   localparam longint WD_NS        = longint'(NSTEPS) * CYC_PER_STEP * CLK_NS;

   logic                  clk;
   logic                  rst_n;
   logic                  core_req_i;
   retire_rec_t           core_rec_i;
   logic                  core_ack_o;
   logic                  ref_req_i;
   retire_rec_t           ref_rec_i;
   logic                  ref_ack_o;
   logic                  core_run_o;
   logic                  ref_step_o;
   logic                  res_req_o;
   logic                  res_ack_i;
   cmp_result_t           res_o;
   logic [`CHK_CNT_W-1:0] pc_checks_o;
   logic [`CHK_CNT_W-1:0] gpr_checks_o;
   logic [`CHK_CNT_W-1:0] miscompares_o;

   // stimulus program and predicted results
   retire_rec_t      core_prog [NSTEPS];
   retire_rec_t      ref_prog  [NSTEPS];
   logic             eager     [NSTEPS];
   int unsigned      ack_dly   [64];
   int unsigned      rel_dly   [64];
   logic [`XLEN-1:0] sw_core   [`NUM_GPR];
   logic [`XLEN-1:0] sw_ref    [`NUM_GPR];
   cmp_result_t      exp_q [$];
   int               n_exp_total;
   int               err_cnt;
   int               fail_cnt;

   tb_clkgen #(.PERIOD_NS(CLK_NS), .RST_CYCLES(10)) u_clkgen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   step_compare_top DUT (
      .ret_rtl       (clk),
      .rst_n_i       (rst_n),
      .core_req_i    (core_req_i),
      .core_rec_i    (core_rec_i),
      .core_ack_o    (core_ack_o),
      .ref_req_i     (ref_req_i),
      .ref_rec_i     (ref_rec_i),
      .ref_ack_o     (ref_ack_o),
      .core_run_o    (core_run_o),
      .ref_step_o    (ref_step_o),
      .res_req_o     (res_req_o),
      .res_ack_i     (res_ack_i),
      .res_o         (res_o),
      .pc_checks_o   (pc_checks_o),
      .gpr_checks_o  (gpr_checks_o),
      .miscompares_o (miscompares_o)
   );

   // sample and drive point sits 2 ns past the rising edge
   task automatic wait_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic check_result(input cmp_result_t exp, input cmp_result_t act);
      if (act !== exp) begin
         err_cnt++;
         $display("ERROR %0t res_o expected=%h actual=%h", $time, exp, act);
      end
   endtask

   task automatic check_count(input string name, input logic [`CHK_CNT_W-1:0] exp,
                              input logic [`CHK_CNT_W-1:0] act);
      if (act !== exp) begin
         err_cnt++;
         $display("ERROR %0t %s expected=%0d actual=%0d", $time, name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         err_cnt++;
         $display("ERROR %0t %s expected=%b actual=%b", $time, name, exp, act);
      end
   endtask

   // expected results of one step with both shadows written before the walk
   function automatic void predict_step(input retire_rec_t c, input retire_rec_t r);
      cmp_result_t res;
      if (c.we && (c.rd != '0))
         sw_core[c.rd] = c.wdata;
      if (r.we && (r.rd != '0))
         sw_ref[r.rd] = r.wdata;
      // pc mismatch goes out first
      if (c.pc != r.pc) begin
         res.kind     = MIS_PC;
         res.idx      = '0;
         res.expected = r.pc;
         res.actual   = c.pc;
         res.pc       = c.pc;
         exp_q.push_back(res);
      end
      // then registers in index order
      for (int i = 0; i < `NUM_GPR; i++) begin
         if (sw_core[i] != sw_ref[i]) begin
            res.kind     = MIS_GPR;
            res.idx      = `GPR_AW'(i);
            res.expected = sw_ref[i];
            res.actual   = sw_core[i];
            res.pc       = c.pc;
            exp_q.push_back(res);
         end
      end
   endfunction

   task automatic build_program();
      retire_rec_t base;
      int unsigned kind;
      int unsigned side;
      for (int i = 0; i < NSTEPS; i++) begin
         base.pc    = 32'h8000_0000 + 32'(i * 4);
         // narrow rd range so registers get rewritten and heal
         base.rd    = `GPR_AW'($urandom_range(15, 0));
         base.wdata = $urandom;
         base.we    = ($urandom_range(7, 0) != 0);
         core_prog[i] = base;
         ref_prog[i]  = base;
         eager[i]     = ($urandom_range(3, 0) == 0);
         // first steps stay identical
         if ((i >= 16) && ($urandom_range(7, 0) == 0)) begin
            kind = $urandom_range(3, 0);
            side = $urandom_range(1, 0);
            if (kind == 3) begin
               // x0 write on one side only while the other side writes nothing
               core_prog[i].we = 1'b0;
               ref_prog[i].we  = 1'b0;
            end
            if (side == 0) begin
               case (kind)
                  0: core_prog[i].pc = base.pc ^ 32'h10;
                  1: core_prog[i].rd = base.rd ^ 5'h1;
                  2: core_prog[i].wdata = base.wdata ^ 32'h100;
                  default: begin
                     core_prog[i].we = 1'b1;
                     core_prog[i].rd = '0;
                  end
               endcase
            end else begin
               case (kind)
                  0: ref_prog[i].pc = base.pc ^ 32'h10;
                  1: ref_prog[i].rd = base.rd ^ 5'h1;
                  2: ref_prog[i].wdata = base.wdata ^ 32'h100;
                  default: begin
                     ref_prog[i].we = 1'b1;
                     ref_prog[i].rd = '0;
                  end
               endcase
            end
         end
      end
      for (int k = 0; k < 64; k++) begin
         ack_dly[k] = $urandom_range(3, 0);
         rel_dly[k] = $urandom_range(3, 0);
      end
   endtask

   // eager core steps raise req without waiting for the run enable
   task automatic drive_core();
      for (int i = 0; i < NSTEPS; i++) begin
         if (!eager[i]) begin
            while (!core_run_o)
               wait_cycle();
         end
         core_rec_i = core_prog[i];
         core_req_i = 1'b1;
         do wait_cycle(); while (!core_ack_o);
         core_req_i = 1'b0;
         do wait_cycle(); while (core_ack_o);
      end
   endtask

   // reference model sends one record per step request
   task automatic drive_ref();
      for (int i = 0; i < NSTEPS; i++) begin
         while (!ref_step_o)
            wait_cycle();
         ref_rec_i = ref_prog[i];
         ref_req_i = 1'b1;
         do wait_cycle(); while (!ref_ack_o);
         ref_req_i = 0;
         do wait_cycle(); while (ref_ack_o);
      end
   endtask

   // result host with slow random ack pops one prediction per handshake
   task automatic serve_results();
      cmp_result_t exp_res;
      int unsigned n;
      n = 0;
      forever begin
         wait_cycle();
         if (res_req_o) begin
            repeat (ack_dly[n % 64]) wait_cycle();
            if (exp_q.size() == 0) begin
               fail_cnt++;
               $display("result handshake at %0t with no result predicted", $time);
            end else begin
               exp_res = exp_q.pop_front();
               check_result(exp_res, res_o);
            end
            res_ack_i = 1'b1;
            while (res_req_o)
               wait_cycle();
            repeat (rel_dly[n % 64]) wait_cycle();
            res_ack_i = 1'b0;
            n++;
         end
      end
   endtask

   // core enable and step request are never up together
   initial begin
      forever begin
         wait_cycle();
         if (rst_n && core_run_o && ref_step_o) begin
            fail_cnt++;
            $display("core ran while the reference step was requested at %0t", $time);
         end
      end
   end

   // watchdog sized from the step count
   initial begin
      #(WD_NS);
      fail_cnt++;
      $display("watchdog expired before all steps were compared");
      $display("errors: value %0d, other %0d", err_cnt, fail_cnt);
      $display("Test FAILED");
      $finish;
   end

   initial begin
      core_req_i = 1'b0;
      core_rec_i = '0;
      ref_req_i  = 1'b0;
      ref_rec_i  = '0;
      res_ack_i  = 1'b0;
      err_cnt    = 0;
      fail_cnt   = 0;
      void'($urandom(32'hdf87));
      for (int i = 0; i < `NUM_GPR; i++) begin
         sw_core[i] = '0;
         sw_ref[i]  = '0;
      end
      build_program();
      for (int i = 0; i < NSTEPS; i++)
         predict_step(core_prog[i], ref_prog[i]);
      n_exp_total = exp_q.size();
      fork
         serve_results();
      join_none

      // outputs quiet in reset
      wait_cycle();
      check_flag("core_run_o", 1'b0, core_run_o);
      check_flag("ref_step_o", 1'b0, ref_step_o);
      check_flag("res_req_o", 1'b0, res_req_o);
      check_flag("core_ack_o", 1'b0, core_ack_o);
      check_flag("ref_ack_o", 1'b0, ref_ack_o);
      check_count("pc_checks_o", '0, pc_checks_o);
      check_count("gpr_checks_o", '0, gpr_checks_o);
      check_count("miscompares_o", '0, miscompares_o);
      while (!rst_n)
         wait_cycle();
      // first edge after release starts the core
      check_flag("core_run_o", 1'b1, core_run_o);

      fork
         drive_core();
         drive_ref();
      join
      // last compare ends when the core is enabled again
      while (!core_run_o)
         wait_cycle();
      wait_cycle();

      check_count("pc_checks_o", `CHK_CNT_W'(NSTEPS), pc_checks_o);
      check_count("gpr_checks_o", `CHK_CNT_W'(NSTEPS * `NUM_GPR), gpr_checks_o);
      check_count("miscompares_o", `CHK_CNT_W'(n_exp_total), miscompares_o);
      if (exp_q.size() != 0) begin
         fail_cnt++;
         $display("%0d predicted results never arrived", exp_q.size());
      end

      $display("errors: value %0d, other %0d", err_cnt, fail_cnt);
      if ((err_cnt == 0) && (fail_cnt == 0)) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 10
) (
   output logic clk_o,
   output logic rst_n_o
);

   // free running clock
   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // reset low for RST_CYCLES rising edges
   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      // release on the falling edge, away from the drive slot
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// ==== hdl/step_compare_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "step_cmp_consts.svh"

module step_compare_top import step_cmp_pkg::*; (
   input  wire                   ret_rtl,
   input  wire                   rst_n_i,
   // core retire link
   input  wire                   core_req_i,
   input  retire_rec_t           core_rec_i,
   output logic                  core_ack_o,
   // reference model retire link
   input  wire                   ref_req_i,
   input  retire_rec_t           ref_rec_i,
   output logic                  ref_ack_o,
   output logic                  core_run_o,
   output logic                  ref_step_o,
   // mismatch results
   output logic                  res_req_o,
   input  wire                   res_ack_i,
   output cmp_result_t           res_o,
   output logic [`CHK_CNT_W-1:0] pc_checks_o,
   output logic [`CHK_CNT_W-1:0] gpr_checks_o,
   output logic [`CHK_CNT_W-1:0] miscompares_o
);

   retire_rec_t        core_rec;
   retire_rec_t        ref_rec;
   logic               core_full;
   logic               ref_full;
   logic               core_consume;
   logic               ref_consume;
   logic               cmp_start;
   logic               cmp_done;
   logic [`GPR_AW-1:0] gpr_idx;
   logic [`XLEN-1:0]   core_gpr;
   logic [`XLEN-1:0]   ref_gpr;

   retire_capture u_core_cap (
      .ret_rtl   (ret_rtl),
      .rst_n_i   (rst_n_i),
      .req_i     (core_req_i),
      .rec_i     (core_rec_i),
      .ack_o     (core_ack_o),
      .consume_i (core_consume),
      .full_o    (core_full),
      .rec_o     (core_rec)
   );

   retire_capture u_ref_cap (
      .ret_rtl   (ret_rtl),
      .rst_n_i   (rst_n_i),
      .req_i     (ref_req_i),
      .rec_i     (ref_rec_i),
      .ack_o     (ref_ack_o),
      .consume_i (ref_consume),
      .full_o    (ref_full),
      .rec_o     (ref_rec)
   );

   // shadows take the record's write in the consume edge
   gpr_shadow u_core_gpr (
      .ret_rtl (ret_rtl),
      .rst_n_i (rst_n_i),
      .we_i    (core_consume && core_rec.we),
      .waddr_i (core_rec.rd),
      .wdata_i (core_rec.wdata),
      .raddr_i (gpr_idx),
      .rdata_o (core_gpr)
   );

   gpr_shadow u_ref_gpr (
      .ret_rtl (ret_rtl),
      .rst_n_i (rst_n_i),
      .we_i    (ref_consume && ref_rec.we),
      .waddr_i (ref_rec.rd),
      .wdata_i (ref_rec.wdata),
      .raddr_i (gpr_idx),
      .rdata_o (ref_gpr)
   );

   step_sequencer u_seq (
      .ret_rtl        (ret_rtl),
      .rst_n_i        (rst_n_i),
      .core_full_i    (core_full),
      .ref_full_i     (ref_full),
      .core_consume_o (core_consume),
      .ref_consume_o  (ref_consume),
      .cmp_start_o    (cmp_start),
      .cmp_done_i     (cmp_done),
      .core_run_o     (core_run_o),
      .ref_step_o     (ref_step_o)
   );

   compare_engine u_eng (
      .ret_rtl       (ret_rtl),
      .rst_n_i       (rst_n_i),
      .cmp_start_i   (cmp_start),
      .core_pc_i     (core_rec.pc),
      .ref_pc_i      (ref_rec.pc),
      .core_gpr_i    (core_gpr),
      .ref_gpr_i     (ref_gpr),
      .gpr_idx_o     (gpr_idx),
      .cmp_done_o    (cmp_done),
      .res_req_o     (res_req_o),
      .res_ack_i     (res_ack_i),
      .res_o         (res_o),
      .pc_checks_o   (pc_checks_o),
      .gpr_checks_o  (gpr_checks_o),
      .miscompares_o (miscompares_o)
   );

endmodule

`default_nettype wire

// ==== hdl/compare_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "step_cmp_consts.svh"

module compare_engine import step_cmp_pkg::*; (
   input  wire                   ret_rtl,
   input  wire                   rst_n_i,
   input  wire                   cmp_start_i,
   input  wire [`XLEN-1:0]       core_pc_i,
   input  wire [`XLEN-1:0]       ref_pc_i,
   input  wire [`XLEN-1:0]       core_gpr_i,
   input  wire [`XLEN-1:0]       ref_gpr_i,
   output logic [`GPR_AW-1:0]    gpr_idx_o,
   output logic                  cmp_done_o,
   // four-phase result link
   output logic                  res_req_o,
   input  wire                   res_ack_i,
   output cmp_result_t           res_o,
   output logic [`CHK_CNT_W-1:0] pc_checks_o,
   output logic [`CHK_CNT_W-1:0] gpr_checks_o,
   output logic [`CHK_CNT_W-1:0] miscompares_o
);

   eng_state_e            state_q;
   logic [`GPR_AW-1:0]    idx_q;
   logic                  req_q;
   logic [`XLEN-1:0]      core_pc_q;
   logic [`XLEN-1:0]      ref_pc_q;
   cmp_result_t           res_q;
   logic [`CHK_CNT_W-1:0] pc_cnt_q;
   logic [`CHK_CNT_W-1:0] gpr_cnt_q;
   logic [`CHK_CNT_W-1:0] mis_cnt_q;
   logic                  pc_mis;
   logic                  gpr_mis;
   logic                  last_idx;

   assign pc_mis   = (core_pc_q != ref_pc_q);
   assign gpr_mis  = (core_gpr_i != ref_gpr_i);
   assign last_idx = (idx_q == `GPR_AW'(`NUM_GPR - 1));

   always_ff @(posedge ret_rtl or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= ENG_IDLE;
         idx_q     <= '0;
         req_q     <= 1'b0;
         pc_cnt_q  <= '0;
         gpr_cnt_q <= '0;
         mis_cnt_q <= '0;
      end else begin
         case (state_q)
            ENG_IDLE: begin
               if (cmp_start_i) begin
                  idx_q   <= '0;
                  state_q <= ENG_PC;
               end
            end
            // one cycle for the pc
            ENG_PC: begin
               pc_cnt_q <= pc_cnt_q + 1'b1;
               if (pc_mis) begin
                  mis_cnt_q <= mis_cnt_q + 1'b1;
                  req_q     <= 1'b1;
                  state_q   <= ENG_REPORT;
               end else begin
                  state_q <= ENG_GPR;
               end
            end
            // one register per cycle, x0 included
            ENG_GPR: begin
               gpr_cnt_q <= gpr_cnt_q + 1'b1;
               if (gpr_mis) begin
                  mis_cnt_q <= mis_cnt_q + 1'b1;
                  req_q     <= 1'b1;
                  state_q   <= ENG_REPORT;
               end else if (last_idx) begin
                  state_q <= ENG_DONE;
               end else begin
                  idx_q <= idx_q + 1'b1;
               end
            end
            ENG_REPORT: begin
               if (req_q) begin
                  // host took it, drop req
                  if (res_ack_i)
                     req_q <= 1'b0;
               end else if (!res_ack_i) begin
                  // handshake closed, resume the walk
                  if (res_q.kind == MIS_PC) begin
                     state_q <= ENG_GPR;
                  end else if (last_idx) begin
                     state_q <= ENG_DONE;
                  end else begin
                     idx_q   <= idx_q + 1'b1;
                     state_q <= ENG_GPR;
                  end
               end
            end
            ENG_DONE: state_q <= ENG_IDLE;
            default:  state_q <= ENG_IDLE;
         endcase
      end
   end

   // pcs held for the whole walk, capture may refill meanwhile
   always_ff @(posedge ret_rtl) begin
      if ((state_q == ENG_IDLE) && cmp_start_i) begin
         core_pc_q <= core_pc_i;
         ref_pc_q  <= ref_pc_i;
      end
   end

   // result payload, stable while req is up
   always_ff @(posedge ret_rtl) begin
      if ((state_q == ENG_PC) && pc_mis) begin
         res_q.kind     <= MIS_PC;
         res_q.idx      <= '0;
         res_q.expected <= ref_pc_q;
         res_q.actual   <= core_pc_q;
         res_q.pc       <= core_pc_q;
      end else if ((state_q == ENG_GPR) && gpr_mis) begin
         res_q.kind     <= MIS_GPR;
         res_q.idx      <= idx_q;
         res_q.expected <= ref_gpr_i;
         res_q.actual   <= core_gpr_i;
         res_q.pc       <= core_pc_q;
      end
   end

   assign gpr_idx_o     = idx_q;
   assign cmp_done_o    = (state_q == ENG_DONE);
   assign res_req_o     = req_q;
   assign res_o         = res_q;
   assign pc_checks_o   = pc_cnt_q;
   assign gpr_checks_o  = gpr_cnt_q;
   assign miscompares_o = mis_cnt_q;

endmodule

`default_nettype wire

// ==== hdl/step_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_sequencer import step_cmp_pkg::*; (
   input  wire   ret_rtl,
   input  wire   rst_n_i,
   input  wire   core_full_i,
   input  wire   ref_full_i,
   output logic  core_consume_o,
   output logic  ref_consume_o,
   output logic  cmp_start_o,
   input  wire   cmp_done_i,
   output logic  core_run_o,
   output logic  ref_step_o
);

   seq_state_e state_q;
   logic       both_ready;

   // both records present, hand them to the compare
   assign both_ready = (state_q == SEQ_STEP_REF) && ref_full_i;

   always_ff @(posedge ret_rtl or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= SEQ_IDLE;
      end else begin
         case (state_q)
            // one cycle out of reset before the core runs
            SEQ_IDLE: state_q <= SEQ_RUN;
            SEQ_RUN: begin
               // core retired, freeze it and ask the model for one step
               if (core_full_i)
                  state_q <= SEQ_STEP_REF;
            end
            SEQ_STEP_REF: begin
               if (both_ready)
                  state_q <= SEQ_CMP;
            end
            SEQ_CMP: begin
               // a core record arriving now waits in its capture
               if (cmp_done_i)
                  state_q <= SEQ_RUN;
            end
            default: state_q <= SEQ_IDLE;
         endcase
      end
   end

   // consume and start fire in the same edge
   // shadows get written in the edge the walk starts
   assign core_consume_o = both_ready;
   assign ref_consume_o  = both_ready;
   assign cmp_start_o    = both_ready;

   // core clock enable
   assign core_run_o = (state_q == SEQ_RUN);
   // step request level, drops with the consume edge
   assign ref_step_o = (state_q == SEQ_STEP_REF);

endmodule

`default_nettype wire

// ==== hdl/gpr_shadow.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "step_cmp_consts.svh"

module gpr_shadow (
   input  wire                ret_rtl,
   input  wire                rst_n_i,
   input  wire                we_i,
   input  wire [`GPR_AW-1:0]  waddr_i,
   input  wire [`XLEN-1:0]    wdata_i,
   input  wire [`GPR_AW-1:0]  raddr_i,
   output logic [`XLEN-1:0]   rdata_o
);

   logic [`XLEN-1:0] regs_q [`NUM_GPR];

   // shadow starts from an all-zero register file
   always_ff @(posedge ret_rtl or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `NUM_GPR; i++)
            regs_q[i] <= '0;
      end else if (we_i && (waddr_i != '0)) begin
         // x0 writes are dropped
         regs_q[waddr_i] <= wdata_i;
      end
   end

   // combinational read, compare walk sees same-edge writes
   assign rdata_o = regs_q[raddr_i];

endmodule

`default_nettype wire

// ==== hdl/retire_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "step_cmp_consts.svh"

module retire_capture import step_cmp_pkg::*; (
   input  wire         ret_rtl,
   input  wire         rst_n_i,
   // four-phase link from the retiring side
   input  wire         req_i,
   input  retire_rec_t rec_i,
   output logic        ack_o,
   // downstream side of the holding register
   input  wire         consume_i,
   output logic        full_o,
   output retire_rec_t rec_o
);

   logic        full_q;
   logic        ack_q;
   retire_rec_t rec_q;
   logic        take;

   // new handshake only when empty and the previous one is finished
   assign take = req_i && !full_q && !ack_q;

   always_ff @(posedge ret_rtl or negedge rst_n_i) begin
      if (!rst_n_i) begin
         full_q <= 1'b0;
         ack_q  <= 1'b0;
      end else begin
         // ack up on empty-to-full only
         if (take) begin
            full_q <= 1'b1;
            ack_q  <= 1'b1;
         end else begin
            if (consume_i)
               full_q <= 1'b0;
            // source has dropped req, close the handshake
            if (ack_q && !req_i)
               ack_q <= 1'b0;
         end
      end
   end

   // holding register, stays valid after consume until next take
   always_ff @(posedge ret_rtl) begin
      if (take)
         rec_q <= rec_i;
   end

   assign ack_o  = ack_q;
   assign full_o = full_q;
   assign rec_o  = rec_q;

endmodule

`default_nettype wire

// ==== hdl/step_cmp_pkg.sv ====
`default_nettype none

`include "step_cmp_consts.svh"

package step_cmp_pkg;

   // one retired instruction with its register write
   typedef struct packed {
      logic [`XLEN-1:0]   pc;
      logic [`GPR_AW-1:0] rd;
      logic [`XLEN-1:0]   wdata;
      logic               we;
   } retire_rec_t;

   // what failed to match
   typedef enum logic {
      MIS_PC,
      MIS_GPR
   } mis_kind_e;

   // expected comes from the reference model, actual from the core
   typedef struct packed {
      mis_kind_e          kind;
      logic [`GPR_AW-1:0] idx;
      logic [`XLEN-1:0]   expected;
      logic [`XLEN-1:0]   actual;
      logic [`XLEN-1:0]   pc;
   } cmp_result_t;

   // lock-step scheduler
   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_RUN,
      SEQ_STEP_REF,
      SEQ_CMP
   } seq_state_e;

   // compare walk
   typedef enum logic [2:0] {
      ENG_IDLE,
      ENG_PC,
      ENG_GPR,
      ENG_REPORT,
      ENG_DONE
   } eng_state_e;

endpackage

`default_nettype wire

// ==== hdl/step_cmp_consts.svh ====
`ifndef STEP_CMP_CONSTS_SVH
`define STEP_CMP_CONSTS_SVH

// pc and register data width
`define XLEN 32

// general purpose registers per hart
`define NUM_GPR 32

// register index width, log2 of NUM_GPR
`define GPR_AW 5

// width of the check and miscompare counters
`define CHK_CNT_W 16

`endif
